// ==== hdl/cpuIsaPkg.sv ====
package cpuIsaPkg;

	localparam int constWidth = 19; // immediate field width, sign extended to 32

	// fixed ISA opcode encoding
	typedef enum logic [4:0] {
		opLd   = 5'd0,
		opLdi  = 5'd1,
		opSt   = 5'd2,
		opAdd  = 5'd3,
		opSub  = 5'd4,
		opAnd  = 5'd5,
		opOr   = 5'd6,
		opShr  = 5'd7,
		opShl  = 5'd8,
		opRor  = 5'd9,
		opRol  = 5'd10,
		opAddi = 5'd11,
		opAndi = 5'd12,
		opOri  = 5'd13,
		opMul  = 5'd14,
		opDiv  = 5'd15,
		opNeg  = 5'd16,
		opNot  = 5'd17,
		opBr   = 5'd18,
		opJr   = 5'd19,
		opJal  = 5'd20,
		opIn   = 5'd21,
		opOut  = 5'd22,
		opMfhi = 5'd23,
		opMflo = 5'd24,
		opNop  = 5'd25,
		opHalt = 5'd26
	} opcodeT;

	typedef logic [3:0] regIndexT;

	// br condition, carried in the low two bits of rb
	typedef enum logic [1:0] {
		condZero,
		condNonzero,
		condPositive,
		condNegative
	} branchCondT;

	typedef struct packed {
		opcodeT opcode;
		regIndexT ra;
		regIndexT rb;
		regIndexT rc;
		logic [14:0] spare;
	} rViewT;

	typedef struct packed {
		opcodeT opcode;
		regIndexT ra;
		regIndexT rb; // top of the 23-bit field
		logic [constWidth-1:0] constant;
	} iViewT;

	typedef union packed {
		rViewT rView; // three-register form
		iViewT iView; // register plus constant form
	} instrWordT;

endpackage

// ==== hdl/datapathCtrlPkg.sv ====
package datapathCtrlPkg;

	localparam int memWords = 512;
	localparam int memAddrWidth = 9;

	// who drives the internal bus
	typedef enum logic [3:0] {
		srcNone    = 4'd0,
		srcRegFile = 4'd1,
		srcPc      = 4'd2,
		srcMdr     = 4'd3,
		srcZLow    = 4'd4,
		srcZHigh   = 4'd5,
		srcHi      = 4'd6,
		srcLo      = 4'd7,
		srcInPort  = 4'd8,
		srcConstC  = 4'd9
	} busSourceT;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr,
		aluShr, aluShl, aluRor, aluRol,
		aluNeg, aluNot, aluMul, aluDiv,
		aluIncPc
	} aluOpT;

	typedef logic [11:0] regEnableT;

	// bit positions in regEnableT
	localparam int enPc      = 0;
	localparam int enIr      = 1;
	localparam int enMar     = 2;
	localparam int enMdr     = 3;
	localparam int enY       = 4;
	localparam int enZ       = 5;
	localparam int enHi      = 6;
	localparam int enLo      = 7;
	localparam int enOutPort = 8;
	localparam int enConFf   = 9;
	localparam int enSpare0  = 10; // reserved
	localparam int enSpare1  = 11; // reserved

endpackage

// ==== hdl/controlBus.sv ====
interface controlBus import datapathCtrlPkg::*; ();

	busSourceT busSource;
	regEnableT regEnable;
	aluOpT aluOp;
	logic gra;
	logic grb;
	logic grc;
	logic rIn;
	logic rOut;
	logic baOut;
	logic memRead;
	logic memWrite;
	logic conFf; // branch decision back to control

	modport control (
		output busSource, regEnable, aluOp, gra, grb, grc, rIn, rOut, baOut,
		output memRead, memWrite,
		input conFf
	);

	modport datapath (
		input busSource, regEnable, aluOp, gra, grb, grc, rIn, rOut, baOut,
		input memRead, memWrite,
		output conFf
	);

endinterface

// ==== hdl/alu.sv ====
module alu import datapathCtrlPkg::*; (
	input logic [31:0] operandA,
	input logic [31:0] operandB,
	input aluOpT op,
	output logic [63:0] result
);

	logic [4:0] shamt;
	logic signed [63:0] product;
	logic signed [31:0] quotient;
	logic signed [31:0] remainder;

	assign shamt = operandB[4:0]; // only the low five bits count
	assign product = $signed(operandA) * $signed(operandB);

	// divide by zero gives quotient 0 and leaves A as remainder
	always_comb begin
		if (operandB == '0) begin
			quotient = '0;
			remainder = $signed(operandA);
		end else begin
			quotient = $signed(operandA) / $signed(operandB);
			remainder = $signed(operandA) % $signed(operandB);
		end
	end

	always_comb begin
		result = '0;
		case (op)
			aluAdd: result[31:0] = operandA + operandB;
			aluSub: result[31:0] = operandA - operandB;
			aluAnd: result[31:0] = operandA & operandB;
			aluOr: result[31:0] = operandA | operandB;
			aluShr: result[31:0] = operandA >> shamt; // logical
			aluShl: result[31:0] = operandA << shamt;
			aluRor: result[31:0] = (operandA >> shamt) | (operandA << (6'd32 - shamt));
			aluRol: result[31:0] = (operandA << shamt) | (operandA >> (6'd32 - shamt));
			aluNeg: result[31:0] = -operandB;
			aluNot: result[31:0] = ~operandB;
			aluMul: result = product;
			aluDiv: result = {remainder, quotient};
			aluIncPc: result[31:0] = operandB + 32'd1;
			default: result = '0;
		endcase
	end

endmodule

// ==== hdl/registerFile.sv ====
module registerFile import cpuIsaPkg::*; (
	input logic Clock,
	input logic Reset,
	input instrWordT ir,
	input logic gra,
	input logic grb,
	input logic grc,
	input logic rIn,
	input logic rOut,
	input logic baOut,
	input logic [31:0] busIn,
	output logic [31:0] busOut
);

	logic [31:0] regs [16];
	regIndexT sel;

	// select-and-encode from the instruction fields
	always_comb begin
		if (gra)
			sel = ir.rView.ra;
		else if (grb)
			sel = ir.rView.rb;
		else if (grc)
			sel = ir.rView.rc;
		else
			sel = '0;
	end

	always_ff @(posedge Clock) begin
		if (rIn)
			regs[sel] <= busIn;
	end

	always_comb begin
		if (baOut && sel == '0)
			busOut = '0; // r0 as base means absolute address
		else if (rOut || baOut)
			busOut = regs[sel];
		else
			busOut = '0;
	end

	assert property (@(posedge Clock) disable iff (Reset) $onehot0({gra, grb, grc}));

endmodule

// ==== hdl/mainMemory.sv ====
module mainMemory import datapathCtrlPkg::*; (
	input logic Clock,
	input logic [memAddrWidth-1:0] address,
	input logic [31:0] writeData,
	input logic write,
	output logic [31:0] readData,
	input logic loadEnable,
	input logic [memAddrWidth-1:0] loadAddress,
	input logic [31:0] loadData
);

	logic [31:0] mem [memWords];

	assign readData = mem[address]; // asynchronous read

	always_ff @(posedge Clock) begin
		if (loadEnable)
			mem[loadAddress] <= loadData; // testbench load wins
		else if (write)
			mem[address] <= writeData;
	end

endmodule

// ==== hdl/datapath.sv ====
module datapath import cpuIsaPkg::*, datapathCtrlPkg::*; (
	input logic Clock,
	input logic Reset,
	controlBus.datapath ctrl,
	input logic [31:0] inPort,
	input logic [31:0] readData,
	output logic [memAddrWidth-1:0] memAddress,
	output logic [31:0] memWriteData,
	output instrWordT ir,
	output logic [31:0] outPort,
	output logic outPortWrite
);

	logic [31:0] bus;
	logic [31:0] regOut;
	logic [31:0] constC;
	logic [63:0] aluResult;
	logic [31:0] pc, mdr, y, hi, lo, inPortReg;
	logic [memAddrWidth-1:0] mar;
	logic [63:0] z;
	logic conFlag;
	logic condMet;

	registerFile regs (
		.Clock(Clock),
		.Reset(Reset),
		.ir(ir),
		.gra(ctrl.gra),
		.grb(ctrl.grb),
		.grc(ctrl.grc),
		.rIn(ctrl.rIn),
		.rOut(ctrl.rOut),
		.baOut(ctrl.baOut),
		.busIn(bus),
		.busOut(regOut)
	);

	alu aluUnit (
		.operandA(y),
		.operandB(bus),
		.op(ctrl.aluOp),
		.result(aluResult)
	);

	assign constC = {{(32 - constWidth){ir.iView.constant[constWidth-1]}}, ir.iView.constant};

	always_comb begin
		case (ctrl.busSource)
			srcRegFile: bus = regOut;
			srcPc: bus = pc;
			srcMdr: bus = mdr;
			srcZLow: bus = z[31:0];
			srcZHigh: bus = z[63:32];
			srcHi: bus = hi;
			srcLo: bus = lo;
			srcInPort: bus = inPortReg;
			srcConstC: bus = constC;
			default: bus = '0; // nobody drives
		endcase
	end

	// positive means strictly greater than zero
	always_comb begin
		case (branchCondT'(ir.rView.rb[1:0]))
			condZero: condMet = (bus == '0);
			condNonzero: condMet = (bus != '0);
			condPositive: condMet = !bus[31] && (bus != '0);
			default: condMet = bus[31]; // negative
		endcase
	end

	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset) begin
			pc <= '0;
			ir <= '0;
			conFlag <= 1'b0;
			outPortWrite <= 1'b0;
		end else begin
			if (ctrl.regEnable[enPc]) pc <= bus;
			if (ctrl.regEnable[enIr]) ir <= bus;
			if (ctrl.regEnable[enConFf]) conFlag <= condMet;
			outPortWrite <= ctrl.regEnable[enOutPort]; // high with the new outPort value
		end
	end

	always_ff @(posedge Clock) begin
		inPortReg <= inPort;
		if (ctrl.regEnable[enMar]) mar <= bus[memAddrWidth-1:0];
		if (ctrl.regEnable[enMdr]) mdr <= ctrl.memRead ? readData : bus;
		if (ctrl.regEnable[enY]) y <= bus;
		if (ctrl.regEnable[enZ]) z <= aluResult;
		if (ctrl.regEnable[enHi]) hi <= bus;
		if (ctrl.regEnable[enLo]) lo <= bus;
		if (ctrl.regEnable[enOutPort]) outPort <= bus;
	end

	assign ctrl.conFf = conFlag;
	assign memAddress = mar;
	assign memWriteData = mdr;

	// IR only loads in fetch2, right after the memory read of fetch1
	assert property (@(posedge Clock) disable iff (Reset)
		ctrl.regEnable[enIr] |-> (ctrl.busSource == srcMdr && $past(ctrl.memRead)));

endmodule

// ==== hdl/controlUnit.sv ====
module controlUnit import cpuIsaPkg::*, datapathCtrlPkg::*; (
	input logic Clock,
	input logic Reset,
	input logic Stop,
	input instrWordT ir,
	controlBus.control ctrl,
	output logic run
);

	typedef enum logic [5:0] {
		resetState, fetch0, fetch1, fetch2, exec3,
		alu3, alu4, alu5,
		imm3, imm4, imm5,
		md3, md4, md5, md6,
		mem3, mem4, mem5, ld6, ld7, st6, st7,
		br3, br4, br5, br6,
		jr3, jal3, jal4, mfhi3, mflo3, in3, out3, nop3,
		haltState
	} stateT;

	stateT state;
	stateT nextState;
	stateT step; // state with the first execute step resolved
	opcodeT opcode;

	function automatic aluOpT aluOpFor(opcodeT op);
		case (op)
			opSub: return aluSub;
			opAnd, opAndi: return aluAnd;
			opOr, opOri: return aluOr;
			opShr: return aluShr;
			opShl: return aluShl;
			opRor: return aluRor;
			opRol: return aluRol;
			opNeg: return aluNeg;
			opNot: return aluNot;
			opMul: return aluMul;
			opDiv: return aluDiv;
			default: return aluAdd; // add, addi, ldi
		endcase
	endfunction

	// first execute state of each instruction class
	function automatic stateT firstStepFor(opcodeT op);
		case (op)
			opAdd, opSub, opAnd, opOr, opShr, opShl,
			opRor, opRol, opNeg, opNot: return alu3;
			opAddi, opAndi, opOri, opLdi: return imm3;
			opMul, opDiv: return md3;
			opLd, opSt: return mem3;
			opBr: return br3;
			opJr: return jr3;
			opJal: return jal3;
			opMfhi: return mfhi3;
			opMflo: return mflo3;
			opIn: return in3;
			opOut: return out3;
			opNop: return nop3;
			default: return haltState; // halt and unused codes
		endcase
	endfunction

	assign opcode = ir.rView.opcode;

	// IR loads as fetch2 ends, so the class is picked from the new IR in exec3
	assign step = (state == exec3) ? firstStepFor(opcode) : state;
	assign run = (step != haltState);

	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset)
			state <= resetState;
		else if (Stop)
			state <= haltState;
		else
			state <= nextState;
	end

	always_comb begin
		nextState = fetch0; // last state of every chain returns to fetch
		case (step)
			fetch0: nextState = fetch1;
			fetch1: nextState = fetch2;
			fetch2: nextState = exec3;
			alu3: nextState = alu4;
			alu4: nextState = alu5;
			imm3: nextState = imm4;
			imm4: nextState = imm5;
			md3: nextState = md4;
			md4: nextState = md5;
			md5: nextState = md6;
			mem3: nextState = mem4;
			mem4: nextState = mem5;
			mem5: nextState = (opcode == opLd) ? ld6 : st6;
			ld6: nextState = ld7;
			st6: nextState = st7;
			br3: nextState = br4;
			br4: nextState = br5;
			br5: nextState = br6;
			jal3: nextState = jal4;
			haltState: nextState = haltState;
			default: nextState = fetch0;
		endcase
	end

	// control word, decoded from the state
	always_comb begin
		ctrl.busSource = srcNone;
		ctrl.regEnable = '0;
		ctrl.aluOp = aluAdd;
		ctrl.gra = 1'b0;
		ctrl.grb = 1'b0;
		ctrl.grc = 1'b0;
		ctrl.rIn = 1'b0;
		ctrl.rOut = 1'b0;
		ctrl.baOut = 1'b0;
		ctrl.memRead = 1'b0;
		ctrl.memWrite = 1'b0;
		case (step)
			fetch0: begin
				ctrl.busSource = srcPc;
				ctrl.regEnable[enMar] = 1'b1;
				ctrl.aluOp = aluIncPc; // Z gets PC+1
				ctrl.regEnable[enZ] = 1'b1;
			end
			fetch1: begin
				ctrl.busSource = srcZLow;
				ctrl.regEnable[enPc] = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.regEnable[enMdr] = 1'b1;
			end
			fetch2: begin
				ctrl.busSource = srcMdr;
				ctrl.regEnable[enIr] = 1'b1;
			end
			alu3, md4: begin
				ctrl.busSource = srcRegFile;
				ctrl.grb = 1'b1;
				ctrl.rOut = 1'b1;
				ctrl.aluOp = aluOpFor(opcode);
				ctrl.regEnable[(step == alu3) ? enY : enZ] = 1'b1;
			end
			alu4: begin
				// neg and not take their operand from rb
				ctrl.busSource = srcRegFile;
				ctrl.grb = (opcode == opNeg) || (opcode == opNot);
				ctrl.grc = !ctrl.grb;
				ctrl.rOut = 1'b1;
				ctrl.aluOp = aluOpFor(opcode);
				ctrl.regEnable[enZ] = 1'b1;
			end
			imm3, mem3: begin
				ctrl.busSource = srcRegFile;
				ctrl.grb = 1'b1;
				ctrl.baOut = (step == mem3) || (opcode == opLdi); // base address, r0 reads 0
				ctrl.rOut = !ctrl.baOut;
				ctrl.regEnable[enY] = 1'b1;
			end
			imm4, mem4, br5: begin
				ctrl.busSource = srcConstC;
				ctrl.aluOp = (step == imm4) ? aluOpFor(opcode) : aluAdd;
				ctrl.regEnable[enZ] = 1'b1;
			end
			alu5, imm5, mfhi3, mflo3, in3, ld7: begin
				ctrl.gra = 1'b1;
				ctrl.rIn = 1'b1;
				case (step)
					mfhi3: ctrl.busSource = srcHi;
					mflo3: ctrl.busSource = srcLo;
					in3: ctrl.busSource = srcInPort;
					ld7: ctrl.busSource = srcMdr;
					default: ctrl.busSource = srcZLow;
				endcase
			end
			md3: begin
				ctrl.busSource = srcRegFile;
				ctrl.gra = 1'b1;
				ctrl.rOut = 1'b1;
				ctrl.regEnable[enY] = 1'b1;
			end
			md5: begin
				ctrl.busSource = srcZLow;
				ctrl.regEnable[enLo] = 1'b1;
			end
			md6: begin
				ctrl.busSource = srcZHigh;
				ctrl.regEnable[enHi] = 1'b1;
			end
			mem5: begin
				ctrl.busSource = srcZLow;
				ctrl.regEnable[enMar] = 1'b1;
			end
			ld6: begin
				ctrl.memRead = 1'b1;
				ctrl.regEnable[enMdr] = 1'b1;
			end
			st6, br3, jr3, jal4, out3: begin
				ctrl.busSource = srcRegFile;
				ctrl.gra = 1'b1;
				ctrl.rOut = 1'b1;
				case (step)
					st6: ctrl.regEnable[enMdr] = 1'b1;
					br3: ctrl.regEnable[enConFf] = 1'b1;
					out3: ctrl.regEnable[enOutPort] = 1'b1;
					default: ctrl.regEnable[enPc] = 1'b1; // jr, jal jump to ra
				endcase
			end
			st7: ctrl.memWrite = 1'b1;
			br4: begin
				ctrl.busSource = srcPc;
				ctrl.regEnable[enY] = 1'b1;
			end
			br6: begin
				ctrl.busSource = srcZLow;
				ctrl.regEnable[enPc] = ctrl.conFf; // taken only if condition held
			end
			jal3: begin
				// link goes to rb before the jump, so ra and rb must differ
				ctrl.busSource = srcPc;
				ctrl.grb = 1'b1;
				ctrl.rIn = 1'b1;
			end
			default: ;
		endcase
	end

	assert property (@(posedge Clock) disable iff (Reset) !(ctrl.memRead && ctrl.memWrite));

	// once stopped, the machine stays stopped and quiet
	assert property (@(posedge Clock) disable iff (Reset)
		!run |=> (!run && ctrl.regEnable == '0 && !ctrl.rIn && !ctrl.memWrite));

endmodule

// ==== hdl/cpuTop.sv ====
module cpuTop import cpuIsaPkg::*, datapathCtrlPkg::*; (
	input logic Clock,
	input logic Reset,
	input logic Stop,
	input logic [31:0] inPort,
	input logic loadEnable,
	input logic [memAddrWidth-1:0] loadAddress,
	input logic [31:0] loadData,
	output logic [31:0] outPort,
	output logic outPortWrite,
	output logic run
);

	controlBus ctrlBus ();

	instrWordT ir;
	logic [memAddrWidth-1:0] memAddress;
	logic [31:0] memWriteData;
	logic [31:0] readData;

	controlUnit control (
		.Clock(Clock),
		.Reset(Reset),
		.Stop(Stop),
		.ir(ir),
		.ctrl(ctrlBus.control),
		.run(run)
	);

	datapath dp (
		.Clock(Clock),
		.Reset(Reset),
		.ctrl(ctrlBus.datapath),
		.inPort(inPort),
		.readData(readData),
		.memAddress(memAddress),
		.memWriteData(memWriteData),
		.ir(ir),
		.outPort(outPort),
		.outPortWrite(outPortWrite)
	);

	mainMemory memory (
		.Clock(Clock),
		.address(memAddress),
		.writeData(memWriteData),
		.write(ctrlBus.memWrite),
		.readData(readData),
		.loadEnable(loadEnable),
		.loadAddress(loadAddress),
		.loadData(loadData)
	);

endmodule

// ==== verification/programTable.svh ====
`ifndef PROGRAMTABLE_SVH
`define PROGRAMTABLE_SVH

// record: name, random in port, fixed in value, stop cycle (0 = none), instruction budget
// then program words from address 0, data words from 256, expected out values
task automatic fillProgramTable();
	logic signed [63:0] product;
	product = -64'sd100000 * 64'sd70000; // signed 64-bit product for mul

	beginRecord("aluOps", 1'b0, 32'd0, 0, 15);
	addInstr(iForm(opLdi, 1, 0, 12));
	addInstr(iForm(opLdi, 2, 0, 35)); // shift amount is 35 & 31 = 3
	addInstr(rForm(opAdd, 3, 1, 2));
	addInstr(rForm(opOut, 3, 0, 0));
	addInstr(rForm(opSub, 3, 1, 2));
	addInstr(rForm(opOut, 3, 0, 0));
	addInstr(rForm(opShl, 3, 1, 2));
	addInstr(rForm(opOut, 3, 0, 0));
	addInstr(rForm(opRor, 3, 1, 2));
	addInstr(rForm(opOut, 3, 0, 0));
	addInstr(rForm(opNeg, 3, 1, 0));
	addInstr(rForm(opOut, 3, 0, 0));
	addInstr(rForm(opNot, 3, 2, 0));
	addInstr(rForm(opOut, 3, 0, 0));
	addInstr(rForm(opHalt, 0, 0, 0));
	addExpected(32'd47);
	addExpected(32'hffff_ffe9); // 12 - 35
	addExpected(32'd96);
	addExpected(32'h8000_0001); // 12 rotated right by 3
	addExpected(32'hffff_fff4);
	addExpected(32'hffff_ffdc);

	beginRecord("immediates", 1'b0, 32'd0, 0, 10);
	addInstr(iForm(opLdi, 1, 0, 100));
	addInstr(iForm(opAddi, 2, 1, -5));
	addInstr(rForm(opOut, 2, 0, 0));
	addInstr(iForm(opAndi, 2, 1, -8));
	addInstr(rForm(opOut, 2, 0, 0));
	addInstr(iForm(opOri, 2, 1, -256));
	addInstr(rForm(opOut, 2, 0, 0));
	addInstr(iForm(opLdi, 3, 0, -1));
	addInstr(rForm(opOut, 3, 0, 0));
	addInstr(rForm(opHalt, 0, 0, 0));
	addExpected(32'd95);
	addExpected(32'd96);
	addExpected(32'hffff_ff64);
	addExpected(32'hffff_ffff);

	beginRecord("memory", 1'b0, 32'd0, 0, 9);
	addInstr(iForm(opLdi, 1, 0, 200));
	addInstr(iForm(opLdi, 2, 0, 77));
	addInstr(iForm(opSt, 2, 1, 100)); // address 300
	addInstr(iForm(opLdi, 3, 0, 250));
	addInstr(iForm(opLd, 4, 3, 50)); // same address 300
	addInstr(rForm(opOut, 4, 0, 0));
	addInstr(iForm(opLd, 5, 0, 256)); // r0 base reads as zero
	addInstr(rForm(opOut, 5, 0, 0));
	addInstr(rForm(opHalt, 0, 0, 0));
	addData(32'h1234_abcd);
	addExpected(32'd77);
	addExpected(32'h1234_abcd);

	beginRecord("branches", 1'b0, 32'd0, 0, 15);
	addInstr(iForm(opLdi, 1, 0, 0));
	addInstr(iForm(opLdi, 2, 0, -3));
	addInstr(iForm(opLdi, 4, 0, 5));
	addInstr(iForm(opBr, 1, condZero, 1)); // taken
	addInstr(rForm(opOut, 1, 0, 0));
	addInstr(iForm(opBr, 1, condNonzero, 1)); // not taken
	addInstr(rForm(opOut, 4, 0, 0));
	addInstr(iForm(opBr, 2, condNegative, 1)); // taken
	addInstr(rForm(opOut, 1, 0, 0));
	addInstr(iForm(opBr, 2, condPositive, 1)); // not taken
	addInstr(rForm(opOut, 2, 0, 0));
	addInstr(iForm(opBr, 4, condPositive, 1)); // taken
	addInstr(rForm(opOut, 1, 0, 0));
	addInstr(rForm(opHalt, 0, 0, 0));
	addExpected(32'd5);
	addExpected(32'hffff_fffd);

	beginRecord("jumps", 1'b0, 32'd0, 0, 8);
	addInstr(iForm(opLdi, 1, 0, 4));
	addInstr(rForm(opJal, 1, 2, 0)); // link in r2 is 2
	addInstr(rForm(opOut, 2, 0, 0));
	addInstr(rForm(opHalt, 0, 0, 0));
	addInstr(rForm(opNop, 0, 0, 0));
	addInstr(iForm(opLdi, 3, 0, 42));
	addInstr(rForm(opOut, 3, 0, 0));
	addInstr(rForm(opJr, 2, 0, 0));
	addExpected(32'd42);
	addExpected(32'd2);

	beginRecord("mulDiv", 1'b0, 32'd0, 0, 15);
	addInstr(iForm(opLdi, 1, 0, -100000));
	addInstr(iForm(opLdi, 2, 0, 70000));
	addInstr(rForm(opMul, 1, 2, 0));
	addInstr(rForm(opMfhi, 3, 0, 0));
	addInstr(rForm(opOut, 3, 0, 0));
	addInstr(rForm(opMflo, 4, 0, 0));
	addInstr(rForm(opOut, 4, 0, 0));
	addInstr(iForm(opLdi, 5, 0, -47));
	addInstr(iForm(opLdi, 6, 0, 5));
	addInstr(rForm(opDiv, 5, 6, 0));
	addInstr(rForm(opMflo, 7, 0, 0));
	addInstr(rForm(opOut, 7, 0, 0));
	addInstr(rForm(opMfhi, 8, 0, 0));
	addInstr(rForm(opOut, 8, 0, 0));
	addInstr(rForm(opHalt, 0, 0, 0));
	addExpected(product[63:32]);
	addExpected(product[31:0]);
	addExpected(32'hffff_fff7); // -47 / 5 truncates to -9
	addExpected(32'hffff_fffe); // remainder -2

	// expected values here are offsets from the random in value
	beginRecord("inPort", 1'b1, 32'd0, 0, 4);
	addInstr(rForm(opIn, 1, 0, 0));
	addInstr(iForm(opAddi, 2, 1, -1234));
	addInstr(rForm(opOut, 2, 0, 0));
	addInstr(rForm(opHalt, 0, 0, 0));
	addExpected(32'hffff_fb2e);

	// endless counting loop, Stop lands during the third addi
	beginRecord("stop", 1'b0, 32'd0, 44, 14);
	addInstr(iForm(opLdi, 1, 0, 0));
	addInstr(iForm(opLdi, 2, 0, 2));
	addInstr(iForm(opAddi, 1, 1, 1));
	addInstr(rForm(opOut, 1, 0, 0));
	addInstr(rForm(opJr, 2, 0, 0));
	addExpected(32'd1);
	addExpected(32'd2);
endtask

`endif

// ==== verification/cpuTb.sv ====
module cpuTb import cpuIsaPkg::*, datapathCtrlPkg::*; ();

	typedef struct {
		string name;
		int progLen;
		logic [31:0] prog [16];
		int dataLen;
		logic [31:0] data [4];
		bit inRandom;
		logic [31:0] inValue;
		int stopCycle; // 0 when Stop is never raised
		int maxInstr;
		int expLen;
		logic [31:0] expected [8];
	} testRecordT;

	localparam int dataBase = 256;

	logic Clock;
	logic Reset;
	logic Stop;
	logic [31:0] inPort;
	logic loadEnable;
	logic [memAddrWidth-1:0] loadAddress;
	logic [31:0] loadData;
	logic [31:0] outPort;
	logic outPortWrite;
	logic run;

	testRecordT tests [8];
	int testCount = 0;
	int seed = 32'hb9c0;
	int cycleCount = 0;
	int cycleLimit = 0;
	int passCount = 0;
	int failCount = 0;

	cpuTop dut (
		.Clock(Clock),
		.Reset(Reset),
		.Stop(Stop),
		.inPort(inPort),
		.loadEnable(loadEnable),
		.loadAddress(loadAddress),
		.loadData(loadData),
		.outPort(outPort),
		.outPortWrite(outPortWrite),
		.run(run)
	);

	always #20 Clock = ~Clock;

	function automatic logic [31:0] rForm(opcodeT op, int ra, int rb, int rc);
		return {op, 4'(ra), 4'(rb), 4'(rc), 15'd0};
	endfunction

	function automatic logic [31:0] iForm(opcodeT op, int ra, int rb, int c);
		return {op, 4'(ra), 4'(rb), 19'(c)}; // constant keeps its low 19 bits
	endfunction

	task automatic beginRecord(input string name, input bit inRandom, input logic [31:0] inValue,
			input int stopCycle, input int maxInstr);
		testCount++;
		tests[testCount-1].name = name;
		tests[testCount-1].inRandom = inRandom;
		tests[testCount-1].inValue = inValue;
		tests[testCount-1].stopCycle = stopCycle;
		tests[testCount-1].maxInstr = maxInstr;
		tests[testCount-1].progLen = 0;
		tests[testCount-1].dataLen = 0;
		tests[testCount-1].expLen = 0;
	endtask

	task automatic addInstr(input logic [31:0] word);
		tests[testCount-1].prog[tests[testCount-1].progLen] = word;
		tests[testCount-1].progLen++;
	endtask

	task automatic addData(input logic [31:0] word);
		tests[testCount-1].data[tests[testCount-1].dataLen] = word;
		tests[testCount-1].dataLen++;
	endtask

	task automatic addExpected(input logic [31:0] value);
		tests[testCount-1].expected[tests[testCount-1].expLen] = value;
		tests[testCount-1].expLen++;
	endtask

	`include "programTable.svh"

	task automatic runTest(input int t);
		logic [31:0] got [$];
		logic [31:0] expValue;
		int errors;
		int cycles;
		int loads;
		bit stopLive;
		errors = 0;
		cycles = 0;
		stopLive = 1'b0;
		@(negedge Clock);
		Reset = 1'b1;
		Stop = 1'b0;
		inPort = tests[t].inRandom ? $random(seed) : tests[t].inValue;
		loads = tests[t].progLen + tests[t].dataLen;
		// one word per cycle, reset held for at least 5 cycles
		for (int i = 0; i < loads || i < 5; i++) begin
			loadEnable = (i < loads);
			if (i < tests[t].progLen) begin
				loadAddress = memAddrWidth'(i);
				loadData = tests[t].prog[i];
			end else if (i < loads) begin
				loadAddress = memAddrWidth'(dataBase + i - tests[t].progLen);
				loadData = tests[t].data[i - tests[t].progLen];
			end
			@(negedge Clock);
		end
		loadEnable = 1'b0;
		Reset = 1'b0;
		while (run) begin
			@(negedge Clock);
			cycles++;
			if (Stop)
				stopLive = 1'b1; // outputs seen now come from the Stop edge or later
			if (outPortWrite) begin
				assert (!stopLive) else begin
					$display("Test %s: an output arrived after Stop was raised", tests[t].name);
					errors++;
				end
				got.push_back(outPort);
			end
			if (cycles == tests[t].stopCycle)
				Stop = 1'b1;
		end
		// a stopped machine stays halted and silent for longer than one loop pass
		if (tests[t].stopCycle != 0) begin
			repeat (16) begin
				@(negedge Clock);
				assert (!run && !outPortWrite) else begin
					$display("Test %s: the machine ran or wrote out after Stop", tests[t].name);
					errors++;
				end
			end
		end
		assert (got.size() == tests[t].expLen) else begin
			$display("Test %s: expected %0d outputs but saw %0d", tests[t].name, tests[t].expLen,
				got.size());
			errors++;
		end
		for (int i = 0; i < tests[t].expLen && i < got.size(); i++) begin
			expValue = tests[t].inRandom ? inPort + tests[t].expected[i] : tests[t].expected[i];
			assert (got[i] === expValue) else begin
				$display("Mismatch at time %0t: test %s position %0d expected %h actual %h",
					$time, tests[t].name, i, expValue, got[i]);
				errors++;
			end
		end
		if (errors == 0) begin
			passCount++;
			$display("Test %-10s PASS with %0d outputs", tests[t].name, got.size());
		end else begin
			failCount++;
			$display("Test %-10s FAIL with %0d errors", tests[t].name, errors);
		end
	endtask

	// watchdog over the whole run
	initial begin
		wait (cycleLimit > 0);
		while (cycleCount < cycleLimit) begin
			@(posedge Clock);
			cycleCount++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
		$display("Regression failed");
		$finish;
	end

	initial begin
		int limit;
		Clock = 1'b0;
		Reset = 1'b1;
		Stop = 1'b0;
		inPort = '0;
		loadEnable = 1'b0;
		loadAddress = '0;
		loadData = '0;
		limit = 0;
		fillProgramTable();
		for (int t = 0; t < testCount; t++)
			limit += 8 * tests[t].maxInstr + 20;
		cycleLimit = 2 * limit;
		for (int t = 0; t < testCount; t++)
			runTest(t);
		$display("Tests run %0d, passed %0d, failed %0d", testCount, passCount, failCount);
		if (failCount == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== cpuProject.f ====
+incdir+verification
hdl/cpuIsaPkg.sv
hdl/datapathCtrlPkg.sv
hdl/controlBus.sv
hdl/alu.sv
hdl/registerFile.sv
hdl/mainMemory.sv
hdl/datapath.sv
hdl/controlUnit.sv
hdl/cpuTop.sv
verification/cpuTb.sv

// ==== runSim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cpuTb \
	-f cpuProject.f -o cpuSim \
	&& ./obj_dir/cpuSim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -qx "Regression passed" sim.log && exit 0 || exit 1
